/* include/line_store_cfg.svh */
// Line store configuration macros for pixel format, line count, buffer depth and counter widths
`ifndef LINE_STORE_CFG_SVH
`define LINE_STORE_CFG_SVH

// Pixel format
`define LS_PPC      4       // Pixels per clock
`define LS_BPC      8       // Bits per component

// Line storage
`define LS_LINES    5       // Line buffers in rotation

// Words per lane, enough for a 3840 pixel line at four pixels per clock
`define LS_DEPTH    2048
`define LS_ADR_W    11      // Lane address width

// Line buffer index, 0 up to LS_LINES-1
`define LS_SEL_W    3

// Vertical line counter and source height
`define LS_VCNT_W   16

`endif

/* source/line_store_pkg.sv */
// Line store package with pixel, line word, lane mask, line index and control struct types
`default_nettype none

package line_store_pkg;

    `include "line_store_cfg.svh"

    typedef logic [`LS_BPC-1:0] pixel_t;           // One component
    typedef pixel_t [`LS_PPC-1:0] line_word_t;     // Lane i sits in element i
    typedef logic [`LS_PPC-1:0] lane_mask_t;       // One bit per pixel lane
    typedef logic [`LS_SEL_W-1:0] line_sel_t;      // Line buffer index

    // Video input, one clock of pixels
    typedef struct packed {
        logic       vs;
        logic       hs;
        logic       de;
        line_word_t dat;
    } video_t;

    // Reader request, levels and single cycle pulses
    typedef struct packed {
        logic       lrst;       // Restore current pair
        logic       lnxt;       // Advance pair by one line
        lane_mask_t rd0;        // Lane strobes, first line
        lane_mask_t rd1;        // Lane strobes, second line
    } line_req_t;

    // Write side of one line buffer
    typedef struct packed {
        logic wr;               // Write strobe
        logic clr;              // Write pointer clear
    } lbuf_wr_t;

    // Next line buffer in the rotation
    function automatic line_sel_t sel_next(input line_sel_t sel);
        if (sel == line_sel_t'(`LS_LINES - 1))
            return '0;
        else
            return sel + line_sel_t'(1);
    endfunction

endpackage

`default_nettype wire

/* source/line_buffer.sv */
// Line buffer with four pixel lanes, a shared write pointer and per-lane read pointers
`timescale 1ns/10ps
`default_nettype none

`include "line_store_cfg.svh"

module line_buffer
(
    input  logic                        CLK_IN,
    input  logic                        RST_IN,
    input  line_store_pkg::lbuf_wr_t    wr,
    input  line_store_pkg::line_word_t  wr_dat,
    input  logic                        rd_clr,
    input  line_store_pkg::lane_mask_t  rd,
    output line_store_pkg::line_word_t  dat
);

    import line_store_pkg::*;

    logic [`LS_ADR_W-1:0] wr_ptr;      // Shared by all lanes

    always_ff @(posedge CLK_IN or posedge RST_IN)
    begin
        if (RST_IN)
            wr_ptr <= '0;
        else if (wr.clr)
            wr_ptr <= '0;
        else if (wr.wr)
            wr_ptr <= wr_ptr + 1'b1;
    end

    genvar l;
    generate
        for (l = 0; l < `LS_PPC; l++)
        begin : gen_lane
            pixel_t                 mem [0:`LS_DEPTH-1];
            logic [`LS_ADR_W-1:0]   rd_ptr;
            pixel_t                 q;

            // Each lane stores its own component of the word
            always_ff @(posedge CLK_IN)
            begin
                if (wr.wr)
                    mem[wr_ptr] <= wr_dat[l];
            end

            // Read pointer, rewound to the start of the line on a clear
            always_ff @(posedge CLK_IN or posedge RST_IN)
            begin
                if (RST_IN)
                    rd_ptr <= '0;
                else if (rd_clr)
                    rd_ptr <= '0;
                else if (rd[l])
                    rd_ptr <= rd_ptr + 1'b1;
            end

            // Pixel appears one cycle after the strobe and holds
            always_ff @(posedge CLK_IN)
            begin
                if (rd[l])
                    q <= mem[rd_ptr];
            end

            assign dat[l] = q;
        end
    endgenerate

endmodule

`default_nettype wire

/* source/line_read_mux.sv */
// Read multiplexer that steers lane strobes to the selected line pair and registers its words
`timescale 1ns/10ps
`default_nettype none

`include "line_store_cfg.svh"

module line_read_mux
(
    input  logic                        CLK_IN,
    input  logic                        RST_IN,
    input  line_store_pkg::line_sel_t   rd_sel,
    input  line_store_pkg::line_req_t   req,
    output line_store_pkg::lane_mask_t  rd       [0:`LS_LINES-1],
    input  line_store_pkg::line_word_t  lbuf_dat [0:`LS_LINES-1],
    output line_store_pkg::line_word_t  dat0,
    output line_store_pkg::line_word_t  dat1
);

    import line_store_pkg::*;

    lane_mask_t rd0_q;         // Reader masks, registered once
    lane_mask_t rd1_q;
    line_sel_t  sel1;          // Second line of the pair

    assign sel1 = sel_next(rd_sel);

    always_ff @(posedge CLK_IN or posedge RST_IN)
    begin
        if (RST_IN)
        begin
            rd0_q <= '0;
            rd1_q <= '0;
        end
        else
        begin
            rd0_q <= req.rd0;
            rd1_q <= req.rd1;
        end
    end

    // Strobes go only to the two buffers of the current pair
    always_ff @(posedge CLK_IN or posedge RST_IN)
    begin
        if (RST_IN)
        begin
            for (int i = 0; i < `LS_LINES; i++)
                rd[i] <= '0;
        end
        else
        begin
            for (int i = 0; i < `LS_LINES; i++)
            begin
                rd[i] <= '0;
                if (rd_sel == line_sel_t'(i))
                    rd[i] <= rd0_q;
                else if (sel1 == line_sel_t'(i))
                    rd[i] <= rd1_q;
            end
        end
    end

    // Output pair, dat0 from the line at sel
    always_ff @(posedge CLK_IN)
    begin
        dat0 <= lbuf_dat[rd_sel];
        dat1 <= lbuf_dat[sel1];    // Wraps to buffer 0 after buffer 4
    end

endmodule

`default_nettype wire

/* source/line_store_ctrl.sv */
// Line store control with video input registers, edge detection, selects, clears, flags and ready
`timescale 1ns/10ps
`default_nettype none

`include "line_store_cfg.svh"

module line_store_ctrl
(
    input  logic                        CLK_IN,
    input  logic                        RST_IN,
    input  logic                        CTL_RUN_IN,
    input  logic [`LS_VCNT_W-1:0]       CTL_VHEIGHT_IN,
    input  line_store_pkg::video_t      vid,
    input  line_store_pkg::line_req_t   req,
    output line_store_pkg::lbuf_wr_t    wr [0:`LS_LINES-1],
    output line_store_pkg::line_word_t  wr_dat,
    output logic [`LS_LINES-1:0]        rd_clr,
    output line_store_pkg::line_sel_t   rd_sel,
    output logic                        rdy
);

    import line_store_pkg::*;

    logic                   run_q;
    logic [`LS_VCNT_W-1:0]  vheight_q;

    // Registered video and the previous sync levels
    logic                   vs_q, hs_q, de_q;
    logic                   vs_d, hs_d, de_d;
    line_word_t             dat_q;
    logic                   vs_re, hs_re, de_fe;

    logic [`LS_VCNT_W-1:0]  vcnt;           // Lines received in this frame
    line_sel_t              wr_sel;         // Buffer being written
    logic                   lrst_q, lnxt_q;
    logic [`LS_LINES-1:0]   wr_clr;
    logic [`LS_LINES-1:0]   av;             // Line holds a complete line

    always_ff @(posedge CLK_IN or posedge RST_IN)
    begin
        if (RST_IN)
        begin
            run_q     <= 1'b0;
            vheight_q <= '0;
            vs_q      <= 1'b0;
            hs_q      <= 1'b0;
            de_q      <= 1'b0;
            vs_d      <= 1'b0;
            hs_d      <= 1'b0;
            de_d      <= 1'b0;
            lrst_q    <= 1'b0;
            lnxt_q    <= 1'b0;
        end
        else
        begin
            run_q     <= CTL_RUN_IN;
            vheight_q <= CTL_VHEIGHT_IN;
            vs_q      <= vid.vs;
            hs_q      <= vid.hs;
            de_q      <= vid.de;
            vs_d      <= vs_q;
            hs_d      <= hs_q;
            de_d      <= de_q;
            lrst_q    <= req.lrst;
            lnxt_q    <= req.lnxt;
        end
    end

    // Pixel word, common to all buffers
    always_ff @(posedge CLK_IN)
        dat_q <= vid.dat;

    assign wr_dat = dat_q;

    assign vs_re = vs_q & ~vs_d;       // Start of frame
    assign hs_re = hs_q & ~hs_d;       // Start of line
    assign de_fe = ~de_q & de_d;       // End of line data

    // Write strobes follow the registered data enable directly
    always_comb
    begin
        for (int i = 0; i < `LS_LINES; i++)
        begin
            wr[i].wr  = run_q & de_q & (wr_sel == line_sel_t'(i));
            wr[i].clr = wr_clr[i];
        end
    end

    // Vertical counter and both selects
    always_ff @(posedge CLK_IN or posedge RST_IN)
    begin
        if (RST_IN)
        begin
            vcnt   <= '0;
            wr_sel <= '0;
            rd_sel <= '0;
        end
        else if (!run_q || vs_re)
        begin
            vcnt   <= '0;
            wr_sel <= '0;
            rd_sel <= '0;
        end
        else
        begin
            if (de_fe)
            begin
                vcnt   <= vcnt + 1'b1;
                wr_sel <= sel_next(wr_sel);     // Wraps 4 to 0
            end
            if (lnxt_q)
                rd_sel <= sel_next(rd_sel);
        end
    end

    // Pointer clears, all of them held while stopped
    always_ff @(posedge CLK_IN or posedge RST_IN)
    begin
        if (RST_IN)
        begin
            wr_clr <= '1;
            rd_clr <= '1;
        end
        else if (!run_q || vs_re)
        begin
            wr_clr <= '1;
            rd_clr <= '1;
        end
        else
        begin
            wr_clr <= '0;
            rd_clr <= '0;
            if (hs_re)
                wr_clr[wr_sel] <= 1'b1;
            if (lrst_q)                         // Rewind the read pair
            begin
                rd_clr[rd_sel]           <= 1'b1;
                rd_clr[sel_next(rd_sel)] <= 1'b1;
            end
        end
    end

    // Available flags, clears win over sets
    always_ff @(posedge CLK_IN or posedge RST_IN)
    begin
        if (RST_IN)
            av <= '0;
        else if (!run_q || vs_q)
            av <= '0;
        else
        begin
            for (int i = 0; i < `LS_LINES; i++)
            begin
                if (lnxt_q && (rd_sel == line_sel_t'(i)))
                    av[i] <= 1'b0;
                else if (lrst_q && (rd_sel == line_sel_t'(i)))
                    av[i] <= 1'b1;
                else if (de_fe && (wr_sel == line_sel_t'(i)))
                    av[i] <= 1'b1;
            end
        end
    end

    // Whole frame in, or both lines of the pair complete
    always_ff @(posedge CLK_IN or posedge RST_IN)
    begin
        if (RST_IN)
            rdy <= 1'b0;
        else if (!run_q)
            rdy <= 1'b0;
        else if (vcnt == vheight_q)
            rdy <= 1'b1;
        else
            rdy <= av[rd_sel] & av[sel_next(rd_sel)];
    end

endmodule

`default_nettype wire

/* source/line_store_top.sv */
// Line store top level with the control module, five line buffers and the read multiplexer
`timescale 1ns/10ps
`default_nettype none

`include "line_store_cfg.svh"

module line_store_top
(
    // Clock and reset
    input  logic                        CLK_IN,
    input  logic                        RST_IN,

    // Control
    input  logic                        CTL_RUN_IN,
    input  logic [`LS_VCNT_W-1:0]       CTL_VHEIGHT_IN,     // Source height in lines

    // Video in
    input  line_store_pkg::video_t      vid,

    // Reader side
    input  line_store_pkg::line_req_t   req,
    output logic                        rdy,
    output line_store_pkg::line_word_t  dat0,
    output line_store_pkg::line_word_t  dat1
);

    import line_store_pkg::*;

    lbuf_wr_t               wr       [0:`LS_LINES-1];   // Write strobe and clear per buffer
    line_word_t             wr_dat;                     // Registered pixel word
    logic [`LS_LINES-1:0]   rd_clr;                     // Read pointer clears
    line_sel_t              rd_sel;                     // First line of the read pair
    lane_mask_t             rd       [0:`LS_LINES-1];   // Lane strobes per buffer
    line_word_t             lbuf_dat [0:`LS_LINES-1];   // Buffer outputs

    // Sequencing, selects and ready
    line_store_ctrl u_ctrl
    (
        .CLK_IN         (CLK_IN),
        .RST_IN         (RST_IN),
        .CTL_RUN_IN     (CTL_RUN_IN),
        .CTL_VHEIGHT_IN (CTL_VHEIGHT_IN),
        .vid            (vid),
        .req            (req),
        .wr             (wr),
        .wr_dat         (wr_dat),
        .rd_clr         (rd_clr),
        .rd_sel         (rd_sel),
        .rdy            (rdy)
    );

    // Line buffers, written round-robin
    genvar i;
    generate
        for (i = 0; i < `LS_LINES; i++)
        begin : gen_lbuf
            line_buffer u_lbuf
            (
                .CLK_IN     (CLK_IN),
                .RST_IN     (RST_IN),
                .wr         (wr[i]),
                .wr_dat     (wr_dat),
                .rd_clr     (rd_clr[i]),
                .rd         (rd[i]),
                .dat        (lbuf_dat[i])
            );
        end
    endgenerate

    // Steers strobes to the pair and collects its words
    line_read_mux u_mux
    (
        .CLK_IN     (CLK_IN),
        .RST_IN     (RST_IN),
        .rd_sel     (rd_sel),
        .req        (req),
        .rd         (rd),
        .lbuf_dat   (lbuf_dat),
        .dat0       (dat0),
        .dat1       (dat1)
    );

endmodule

`default_nettype wire

/* verification/tb_line_store.sv */
// Line store testbench with golden file stimulus, read checks, a compare task and a watchdog
`timescale 1ns/10ps
`default_nettype none

`include "line_store_cfg.svh"

module tb_line_store;

    import line_store_pkg::*;

    localparam int GOLD_WORDS = 256;
    localparam int HDR_WORDS  = 4;      // Height, words per line, lines, records

    logic                   CLK_IN;
    logic                   RST_IN;
    logic                   CTL_RUN_IN;
    logic [`LS_VCNT_W-1:0]  CTL_VHEIGHT_IN;
    video_t                 vid;
    line_req_t              req;
    logic                   rdy;
    line_word_t             dat0;
    line_word_t             dat1;

    logic [31:0]            gold [0:GOLD_WORDS-1];
    int                     height;
    int                     len;            // Words per line
    int                     n_lines;
    int                     n_recs;
    int                     checks;
    int                     errors;
    logic                   loaded;

    line_store_top u_dut
    (
        .CLK_IN         (CLK_IN),
        .RST_IN         (RST_IN),
        .CTL_RUN_IN     (CTL_RUN_IN),
        .CTL_VHEIGHT_IN (CTL_VHEIGHT_IN),
        .vid            (vid),
        .req            (req),
        .rdy            (rdy),
        .dat0           (dat0),
        .dat1           (dat1)
    );

    // 4 ns clock
    initial
    begin
        CLK_IN = 1'b0;
        forever
            #2 CLK_IN = ~CLK_IN;
    end

    task automatic compare_value(input logic [31:0] got, input logic [31:0] exp,
                                 input string what);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge CLK_IN);
    endtask

    // Vsync high for four cycles, then low
    task automatic pulse_vsync;
        @(posedge CLK_IN);
        vid.vs <= 1'b1;
        wait_cycles(4);
        vid.vs <= 1'b0;
        wait_cycles(4);
    endtask

    // Hsync first, then one word per clock with de high
    task automatic write_line(input int n);
        int base;
        base = HDR_WORDS + n * len;
        @(posedge CLK_IN);
        vid.hs <= 1'b1;
        wait_cycles(2);
        vid.hs <= 1'b0;
        wait_cycles(2);
        for (int j = 0; j < len; j++)
        begin
            vid.de  <= 1'b1;
            vid.dat <= gold[base + j];
            @(posedge CLK_IN);
        end
        vid.de  <= 1'b0;
        vid.dat <= '0;
        wait_cycles(4);         // Lets the write select move on
    endtask

    // One read-check record: request word, rdy, dat0, dat1
    task automatic play_record(input int r);
        int         base;
        line_req_t  cmd;
        logic       restart;
        base    = HDR_WORDS + n_lines * len + r * 4;
        cmd     = line_req_t'(gold[base][9:0]);
        restart = gold[base][12];
        if (restart)
            pulse_vsync();
        else
        begin
            @(posedge CLK_IN);
            req <= cmd;
            @(posedge CLK_IN);
            req <= '0;
            wait_cycles(3);     // Data lands four cycles after the mask
        end
        @(negedge CLK_IN);
        compare_value(rdy, gold[base + 1], $sformatf("rdy in record %0d", r));
        if (!restart && !cmd.lrst && !cmd.lnxt)
        begin
            compare_value(dat0, gold[base + 2], $sformatf("dat0 in record %0d", r));
            compare_value(dat1, gold[base + 3], $sformatf("dat1 in record %0d", r));
        end
    endtask

    task automatic run_tests;
        height  = gold[0];
        len     = gold[1];
        n_lines = gold[2];
        n_recs  = gold[3];
        loaded  = 1'b1;

        wait_cycles(8);
        RST_IN <= 1'b0;

        // Stopped, so rdy must stay low
        for (int i = 0; i < 8; i++)
        begin
            @(negedge CLK_IN);
            compare_value(rdy, 0, "rdy while stopped");
        end

        @(posedge CLK_IN);
        CTL_RUN_IN     <= 1'b1;
        CTL_VHEIGHT_IN <= gold[0][`LS_VCNT_W-1:0];
        wait_cycles(2);
        pulse_vsync();

        // Pair 0 and 1 is ready after two lines, or once the frame is in
        for (int n = 0; n < n_lines; n++)
        begin
            write_line(n);
            @(negedge CLK_IN);
            compare_value(rdy, (n + 1 >= 2) || (n + 1 == height),
                          $sformatf("rdy after line %0d", n));
        end

        wait_cycles(8);
        for (int r = 0; r < n_recs; r++)
            play_record(r);
    endtask

    initial
    begin
        checks         = 0;
        errors         = 0;
        loaded         = 1'b0;
        RST_IN         = 1'b1;
        CTL_RUN_IN     = 1'b0;
        CTL_VHEIGHT_IN = '0;
        vid            = '0;
        req            = '0;
        $readmemh("verification/line_store_golden.txt", gold);
        if ($isunknown(gold[3]))
        begin
            $display("The golden file could not be read, no test was run");
            errors++;
        end
        else
            run_tests();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

    // Watchdog, sized from the golden file
    initial
    begin
        int limit;
        wait (loaded);
        limit = (n_lines + n_recs) * len * 8 + 400;
        repeat (limit) @(posedge CLK_IN);
        $display("Timeout: the run did not finish within %0d cycles", limit);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

/* verification/line_store_golden.txt */
// Header: height, words per line, lines written, read-check records
// Then one row of pixel words per line; then records of request, rdy, dat0, dat1
// Request bits: 12 vsync restart, 9 restore, 8 next, 7:4 rd0 lanes, 3:0 rd1 lanes
00000005 00000004 00000005 00000014
03020100 07060504 0b0a0908 0f0e0d0c
13121110 17161514 1b1a1918 1f1e1d1c
23222120 27262524 2b2a2928 2f2e2d2c
33323130 37363534 3b3a3938 3f3e3d3c
43424140 47464544 4b4a4948 4f4e4d4c
// Full reads of lines 0 and 1, then lane 0 alone
000000ff 00000001 03020100 13121110
000000ff 00000001 07060504 17161514
00000010 00000001 07060508 17161514
000000ff 00000001 0b0a090c 1b1a1918
// Restore and read again from the first word
00000200 00000001 00000000 00000000
000000ff 00000001 03020100 13121110
// Next through all five buffers, wrapping to buffer 0
00000100 00000001 00000000 00000000
000000ff 00000001 17161514 23222120
00000100 00000001 00000000 00000000
000000ff 00000001 27262524 33323130
00000100 00000001 00000000 00000000
000000ff 00000001 37363534 43424140
00000100 00000001 00000000 00000000
000000ff 00000001 47464544 07060504
00000100 00000001 00000000 00000000
00000200 00000001 00000000 00000000
000000ff 00000001 03020100 13121110
// New frame start, reads return to line 0
00001000 00000000 00000000 00000000
000000ff 00000000 03020100 13121110
000000ff 00000000 07060504 17161514

/* verilog.f */
+incdir+include
source/line_store_pkg.sv
source/line_buffer.sv
source/line_read_mux.sv
source/line_store_ctrl.sv
source/line_store_top.sv
verification/tb_line_store.sv

/* Bender.yml */
package:
  name: line_store

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/line_store_pkg.sv
      - source/line_buffer.sv
      - source/line_read_mux.sv
      - source/line_store_ctrl.sv
      - source/line_store_top.sv

  - target: test
    include_dirs:
      - include
    files:
      - verification/tb_line_store.sv
